// ==== verilog/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry, 16 sets of 4 words in 2 ways

`define DC_INDEX_W 4 // set index bits
`define DC_WOFF_W  2 // word offset bits inside a line

// tag takes what is left of the 32-bit address after index, word and byte offset
`define DC_TAG_W   (32 - `DC_INDEX_W - `DC_WOFF_W - 2)

`define DC_WAYS    2

`endif

// ==== verilog/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    // address as seen by the cache
    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_WOFF_W-1:0]  woff;  // word inside the line
        logic [1:0]             boff;  // byte inside the word
    } addr_fields_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tagv_t;

    typedef logic [(1 << `DC_WOFF_W)-1:0][31:0] line_t;  // word 0 in the low bits
    typedef logic [(4 << `DC_WOFF_W)-1:0]       line_strb_t;

    // a zero strobe marks a read
    typedef struct packed {
        addr_fields_t addr;
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
    } dc_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } dc_resp_t;

endpackage

// ==== verilog/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // burst memory bus, four 32-bit beats per line, lowest word first

    typedef struct packed {
        logic [31:0] addr;  // line aligned
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_rd_beat_t;

    typedef struct packed {
        logic [31:0] addr;  // line aligned
    } mem_wr_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_wr_beat_t;

endpackage

// ==== verilog/way_ram.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module way_ram #(
    parameter type entry_t = dcache_pkg::line_t
) (
    input  logic                   clk,
    input  logic [`DC_INDEX_W-1:0] rd_index,
    input  logic [`DC_INDEX_W-1:0] wr_index,
    input  dcache_pkg::line_strb_t wr_en,    // one bit per byte lane
    input  entry_t                 wr_data,
    output entry_t                 rd_data
);
    localparam int SETS  = 1 << `DC_INDEX_W;
    localparam int W     = $bits(entry_t);
    localparam int LANES = (W + 7) / 8;  // a partial top lane is padded

    logic [LANES*8-1:0] mem [SETS];
    logic [LANES*8-1:0] wr_pad;

    always_comb begin
        wr_pad        = '0;
        wr_pad[W-1:0] = wr_data;
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (wr_en[l]) begin
                mem[wr_index][l*8 +: 8] <= wr_pad[l*8 +: 8];
            end
        end
        rd_data <= entry_t'(mem[rd_index][W-1:0]);  // data one cycle after index
    end

    // the controller's buffered index must be settled whenever it writes
    a_wr_index_known: assert property (
        @(posedge clk) (|wr_en) |-> !$isunknown(wr_index)
    ) else $error("way_ram write with unknown index");

endmodule

// ==== verilog/replace_state.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module replace_state (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DC_INDEX_W-1:0] index,       // buffered request index
    input  logic                   hit_upd,
    input  logic                   hit_way,
    input  logic                   refill_upd,
    input  logic                   refill_way,
    input  logic                   is_write,
    output logic                   victim_way,
    output logic                   victim_dirty
);
    localparam int SETS = 1 << `DC_INDEX_W;

    logic [SETS-1:0]               lru;    // points at the least recently used way
    logic [`DC_WAYS-1:0][SETS-1:0] dirty;

    //////////////////////////////////////////////////////////////////////
    // update on hit or refill, visible one cycle later
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru   <= '0;
            dirty <= '0;
        end else begin
            if (hit_upd) begin
                lru[index] <= ~hit_way;  // the other way becomes lru
                if (is_write) begin
                    dirty[hit_way][index] <= 1'b1;
                end
            end
            if (refill_upd) begin
                lru[index]               <= ~refill_way;
                dirty[refill_way][index] <= is_write;  // a store miss leaves the line dirty
            end
        end
    end

    // victim select for the buffered set
    assign victim_way   = lru[index];
    assign victim_dirty = dirty[victim_way][index];

    // one request at a time, so a hit and a refill never land together
    a_single_update: assert property (
        @(posedge clk) disable iff (!rstn) !(hit_upd && refill_upd)
    ) else $error("replace_state hit and refill update in one cycle");

endmodule

// ==== verilog/writeback_unit.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module writeback_unit (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     victim_dirty,
    input  dcache_pkg::line_t        victim_line,
    input  logic [`DC_TAG_W-1:0]     victim_tag,
    input  logic [`DC_INDEX_W-1:0]   index,
    output logic                     wb_done,
    output logic                     mem_wr_valid,
    output mem_bus_pkg::mem_wr_req_t mem_wr_req,
    output mem_bus_pkg::mem_wr_beat_t mem_wr_beat,
    input  logic                     mem_wr_ready,
    input  logic                     mem_b_valid,
    output logic                     mem_b_ready
);
    import dcache_pkg::*;

    localparam int WORDS = 1 << `DC_WOFF_W;

    typedef enum logic [1:0] {INIT, WRITE, FINISH} wb_state_t;

    wb_state_t              state, next_state;
    logic [`DC_WOFF_W-1:0]  cnt;        // beats sent so far
    logic                   data_sent;  // all beats out, waiting for the response
    line_t                  vbuf;       // victim buffer
    logic [31:0]            waddr;
    logic                   beat_fire;

    assign beat_fire = mem_wr_valid && mem_wr_ready;

    //////////////////////////////////////////////////////////////////////
    // write-back FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            INIT, FINISH: if (start) next_state = victim_dirty ? WRITE : FINISH;
            WRITE:        if (mem_b_valid && mem_b_ready) next_state = FINISH;
            default:      next_state = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= INIT;
            cnt       <= '0;
            data_sent <= 1'b0;
        end else begin
            state <= next_state;
            if (start) begin
                cnt       <= '0;
                data_sent <= 1'b0;
            end else if (beat_fire) begin
                cnt <= cnt + 1'b1;  // wraps to zero after the last beat
                if (mem_wr_beat.last) data_sent <= 1'b1;
            end
        end
    end

    // latch the victim when the miss is seen, then shift one word per beat
    always_ff @(posedge clk) begin
        if (start) begin
            vbuf  <= victim_line;
            waddr <= {victim_tag, index, {(`DC_WOFF_W + 2){1'b0}}};
        end else if (beat_fire) begin
            vbuf <= {32'b0, vbuf[WORDS-1:1]};
        end
    end

    assign mem_wr_valid     = (state == WRITE) && !data_sent;
    assign mem_b_ready      = (state == WRITE) && data_sent;
    assign mem_wr_req.addr  = waddr;
    assign mem_wr_beat.data = vbuf[0];
    assign mem_wr_beat.last = (cnt == WORDS - 1);
    assign wb_done          = (state == FINISH);  // held until the next start

    // counter must be back at zero whenever the channel is idle
    a_last_with_valid: assert property (
        @(posedge clk) disable iff (!rstn) mem_wr_beat.last |-> mem_wr_valid
    ) else $error("write beat last without valid");

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                      clk,
    input  logic                      rstn,
    // pipeline
    input  logic                      req_valid,
    input  dcache_pkg::dc_req_t       req,
    output logic                      resp_valid,
    output dcache_pkg::dc_resp_t      resp,
    // memory read channel
    output logic                      mem_rd_valid,
    output mem_bus_pkg::mem_rd_req_t  mem_rd_req,
    input  logic                      mem_rd_ready,
    input  mem_bus_pkg::mem_rd_beat_t mem_rd_beat,
    // way rams
    output logic [`DC_INDEX_W-1:0]    rd_index,
    output logic [`DC_INDEX_W-1:0]    wr_index,
    input  dcache_pkg::tagv_t         tag_rdata  [`DC_WAYS],
    input  dcache_pkg::line_t         line_rdata [`DC_WAYS],
    output dcache_pkg::line_strb_t    tag_we     [`DC_WAYS],
    output dcache_pkg::tagv_t         tag_wdata,
    output dcache_pkg::line_strb_t    line_we    [`DC_WAYS],
    output dcache_pkg::line_t         line_wdata,
    // replacement state
    output logic                      hit_upd,
    output logic                      hit_way,
    output logic                      refill_upd,
    output logic                      refill_way,
    output logic                      is_write,
    input  logic                      victim_way,
    // write-back unit
    output logic                      wb_start,
    output dcache_pkg::line_t         victim_line,
    output logic [`DC_TAG_W-1:0]      victim_tag,
    input  logic                      wb_done
);
    import dcache_pkg::*;

    localparam int WORDS = 1 << `DC_WOFF_W;
    localparam int SETS  = 1 << `DC_INDEX_W;

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REFILL, WAIT_WRITE} state_t;

    state_t               state, next_state;
    dc_req_t              req_q;      // request buffer
    line_t                ret_buf;    // return buffer, filled by the read burst
    logic [`DC_WAYS-1:0]  hit;
    logic                 cache_hit;
    logic                 rd_fire;
    line_strb_t           line_strb;  // store strobe placed at its word
    logic [31:0]          hit_word;
    logic [31:0]          ret_word;
    logic [`DC_WAYS-1:0][SETS-1:0] line_valid;  // per way and set, set on refill

    //////////////////////////////////////////////////////////////////////
    // request and return buffers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
        if (rd_fire) begin
            ret_buf <= {mem_rd_beat.data, ret_buf[WORDS-1:1]};  // lowest word arrives first
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            line_valid <= '0;
        end else if (state == REFILL) begin
            line_valid[victim_way][req_q.addr.index] <= 1'b1;
        end
    end

    assign rd_fire  = mem_rd_valid && mem_rd_ready;
    assign is_write = |req_q.wstrb;
    assign rd_index = req.addr.index;   // ram read starts with the incoming request
    assign wr_index = req_q.addr.index;

    // tag compare
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = line_valid[w][req_q.addr.index] && tag_rdata[w].valid
                     && (tag_rdata[w].tag == req_q.addr.tag);
        end
    end
    assign cache_hit = |hit;
    assign hit_way   = hit[1];  // only meaningful on a hit

    // store data, merged over the returned line
    // on a hit only the strobed bytes are written, so the same line serves both
    assign line_strb = line_strb_t'(req_q.wstrb) << {req_q.addr.woff, 2'b00};
    always_comb begin
        for (int w = 0; w < WORDS; w++) begin
            for (int b = 0; b < 4; b++) begin
                line_wdata[w][b*8 +: 8] = line_strb[w*4 + b] ? req_q.wdata[b*8 +: 8]
                                                             : ret_buf[w][b*8 +: 8];
            end
        end
    end

    assign tag_wdata.valid = 1'b1;
    assign tag_wdata.tag   = req_q.addr.tag;
    assign refill_way      = victim_way;
    assign victim_line     = line_rdata[victim_way];
    assign victim_tag      = tag_rdata[victim_way].tag;
    assign mem_rd_req.addr = {req_q.addr.tag, req_q.addr.index, {(`DC_WOFF_W + 2){1'b0}}};

    assign hit_word = line_rdata[hit_way][req_q.addr.woff];
    assign ret_word = ret_buf[req_q.addr.woff];

    //////////////////////////////////////////////////////////////////////
    // main FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:       if (req_valid) next_state = LOOKUP;
            LOOKUP:     next_state = cache_hit ? IDLE : MISS;
            MISS:       if (rd_fire && mem_rd_beat.last) next_state = REFILL;
            REFILL:     next_state = WAIT_WRITE;
            WAIT_WRITE: if (wb_done) next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    always_comb begin
        resp_valid   = 1'b0;
        resp.rdata   = 32'b0;
        mem_rd_valid = 1'b0;
        tag_we       = '{default: '0};
        line_we      = '{default: '0};
        hit_upd      = 1'b0;
        refill_upd   = 1'b0;
        wb_start     = 1'b0;
        case (state)
            LOOKUP: begin
                if (cache_hit) begin
                    line_we[hit_way] = line_strb;  // store hit, strobed bytes only
                    hit_upd          = 1'b1;
                    resp_valid       = 1'b1;
                    resp.rdata       = is_write ? 32'b0 : hit_word;
                end else begin
                    wb_start = 1'b1;  // victim is on the ram outputs now
                end
            end
            MISS: mem_rd_valid = 1'b1;
            REFILL: begin
                tag_we[victim_way]  = '1;
                line_we[victim_way] = '1;
                refill_upd          = 1'b1;
            end
            WAIT_WRITE: begin
                resp_valid = wb_done;
                resp.rdata = (wb_done && !is_write) ? ret_word : 32'b0;
            end
            default: ;
        endcase
    end

    // every request ends in IDLE, so a response never repeats
    a_resp_strobe: assert property (
        @(posedge clk) disable iff (!rstn) resp_valid |=> !resp_valid
    ) else $error("resp_valid high for two cycles");

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req_valid,
    input  dcache_pkg::dc_req_t        req,
    output logic                       resp_valid,
    output dcache_pkg::dc_resp_t       resp,
    output logic                       mem_rd_valid,
    output mem_bus_pkg::mem_rd_req_t   mem_rd_req,
    input  logic                       mem_rd_ready,
    input  mem_bus_pkg::mem_rd_beat_t  mem_rd_beat,
    output logic                       mem_wr_valid,
    output mem_bus_pkg::mem_wr_req_t   mem_wr_req,
    output mem_bus_pkg::mem_wr_beat_t  mem_wr_beat,
    input  logic                       mem_wr_ready,
    input  logic                       mem_b_valid,
    output logic                       mem_b_ready
);
    import dcache_pkg::*;

    logic [`DC_INDEX_W-1:0] rd_index, wr_index;
    tagv_t                  tag_rdata  [`DC_WAYS];
    line_t                  line_rdata [`DC_WAYS];
    line_strb_t             tag_we     [`DC_WAYS];
    line_strb_t             line_we    [`DC_WAYS];
    tagv_t                  tag_wdata;
    line_t                  line_wdata;
    logic                   hit_upd, hit_way, refill_upd, refill_way, is_write;
    logic                   victim_way, victim_dirty;
    logic                   wb_start, wb_done;
    line_t                  victim_line;
    logic [`DC_TAG_W-1:0]   victim_tag;

    dcache_ctrl u_ctrl (
        .clk, .rstn, .req_valid, .req, .resp_valid, .resp,
        .mem_rd_valid, .mem_rd_req, .mem_rd_ready, .mem_rd_beat,
        .rd_index, .wr_index, .tag_rdata, .line_rdata,
        .tag_we, .tag_wdata, .line_we, .line_wdata,
        .hit_upd, .hit_way, .refill_upd, .refill_way, .is_write, .victim_way,
        .wb_start, .victim_line, .victim_tag, .wb_done
    );

    //////////////////////////////////////////////////////////////////////
    // way storage, tags and lines share the indices
    //////////////////////////////////////////////////////////////////////

    way_ram #(.entry_t(tagv_t)) tag_ram0 (
        .clk, .rd_index, .wr_index,
        .wr_en(tag_we[0]), .wr_data(tag_wdata), .rd_data(tag_rdata[0])
    );
    way_ram #(.entry_t(tagv_t)) tag_ram1 (
        .clk, .rd_index, .wr_index,
        .wr_en(tag_we[1]), .wr_data(tag_wdata), .rd_data(tag_rdata[1])
    );
    way_ram #(.entry_t(line_t)) data_ram0 (
        .clk, .rd_index, .wr_index,
        .wr_en(line_we[0]), .wr_data(line_wdata), .rd_data(line_rdata[0])
    );
    way_ram #(.entry_t(line_t)) data_ram1 (
        .clk, .rd_index, .wr_index,
        .wr_en(line_we[1]), .wr_data(line_wdata), .rd_data(line_rdata[1])
    );

    replace_state u_replace (
        .clk, .rstn, .index(wr_index),
        .hit_upd, .hit_way, .refill_upd, .refill_way, .is_write,
        .victim_way, .victim_dirty
    );

    writeback_unit u_wb (
        .clk, .rstn, .start(wb_start), .victim_dirty, .victim_line, .victim_tag,
        .index(wr_index), .wb_done,
        .mem_wr_valid, .mem_wr_req, .mem_wr_beat, .mem_wr_ready,
        .mem_b_valid, .mem_b_ready
    );

endmodule

// ==== sim/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] PATTERN = 32'h0,
    parameter int unsigned SEED    = 1
) (
    input  logic                      clk,
    input  logic                      mem_rd_valid,
    input  mem_bus_pkg::mem_rd_req_t  mem_rd_req,
    output logic                      mem_rd_ready,
    output mem_bus_pkg::mem_rd_beat_t mem_rd_beat,
    input  logic                      mem_wr_valid,
    input  mem_bus_pkg::mem_wr_req_t  mem_wr_req,
    input  mem_bus_pkg::mem_wr_beat_t mem_wr_beat,
    output logic                      mem_wr_ready,
    output logic                      mem_b_valid,
    input  logic                      mem_b_ready,
    output int                        rd_bursts,
    output mem_bus_pkg::mem_rd_req_t  last_rd,
    output int                        wr_bursts,
    output mem_bus_pkg::mem_wr_req_t  last_wr
);
    import mem_bus_pkg::*;

    localparam int WORDS = 1024;  // 4 KB window at address zero

    logic [31:0] shadow [WORDS];
    int          rd_beat;
    int          wr_beat;
    bit          wr_last_ok;  // last seen only on the fourth beat of this burst

    // one process drives every bus input on the falling edge
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = (i << 2) ^ PATTERN;  // word holds its own address
        end
        {mem_rd_ready, mem_wr_ready, mem_b_valid} = '0;
        mem_rd_beat = '0;
        {rd_bursts, wr_bursts, rd_beat, wr_beat} = '0;
        wr_last_ok = 1'b0;
        last_rd = '0;
        last_wr = '0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            // random back-pressure, about one cycle in four
            mem_rd_ready = mem_rd_valid && ($urandom % 4 != 0);
            mem_wr_ready = mem_wr_valid && ($urandom % 4 != 0);
            mem_b_valid  = mem_b_ready && ($urandom % 4 != 0);
            if (mem_rd_ready) begin
                if (rd_beat == 0) begin
                    rd_bursts++;
                    last_rd = mem_rd_req;
                end
                mem_rd_beat.data = shadow[int'(mem_rd_req.addr[11:2]) + rd_beat];
                mem_rd_beat.last = (rd_beat == 3);
                rd_beat = (rd_beat + 1) % 4;
            end
            if (mem_wr_ready) begin
                shadow[int'(mem_wr_req.addr[11:2]) + wr_beat] = mem_wr_beat.data;
                if (wr_beat == 0) begin
                    wr_last_ok = 1'b1;
                end
                if (mem_wr_beat.last !== (wr_beat == 3)) begin
                    wr_last_ok = 1'b0;  // a misplaced last keeps the burst out of the count
                end
                if (wr_beat == 3 && wr_last_ok) begin
                    wr_bursts++;  // counted on the beat with last
                    last_wr = mem_wr_req;
                end
                wr_beat = (wr_beat + 1) % 4;
            end
        end
    end

endmodule

// ==== sim/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    localparam logic [31:0] PATTERN   = 32'hC0DE_5A5A;
    localparam int          SEED      = 84;
    localparam int          RST_CYC   = 8;
    localparam int          ENTRY_CYC = 200;
    localparam logic [31:0] ST1       = 32'hAABB_CCDD;
    localparam logic [31:0] ST2       = 32'h1122_3344;

    typedef struct packed {
        bit          wr;         // op, store when set
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;  // zero for stores
        bit          exp_rd;     // one read burst expected
        bit          exp_wb;     // one write-back burst expected
        logic [31:0] wb_addr;
    } stim_t;

    logic         clk = 1'b0;
    logic         rstn;
    logic         req_valid;
    dc_req_t      req;
    logic         resp_valid;
    dc_resp_t     resp;
    logic         mem_rd_valid, mem_rd_ready;
    mem_rd_req_t  mem_rd_req;
    mem_rd_beat_t mem_rd_beat;
    logic         mem_wr_valid, mem_wr_ready, mem_b_valid, mem_b_ready;
    mem_wr_req_t  mem_wr_req;
    mem_wr_beat_t mem_wr_beat;
    int           rd_bursts, wr_bursts;
    mem_rd_req_t  last_rd;
    mem_wr_req_t  last_wr;

    stim_t tbl[$];
    int    cycles = 0;
    int    cycle_limit;

    dcache_top uut (
        .clk, .rstn, .req_valid, .req, .resp_valid, .resp,
        .mem_rd_valid, .mem_rd_req, .mem_rd_ready, .mem_rd_beat,
        .mem_wr_valid, .mem_wr_req, .mem_wr_beat, .mem_wr_ready,
        .mem_b_valid, .mem_b_ready
    );

    mem_model #(.PATTERN(PATTERN), .SEED(SEED)) u_mem (
        .clk, .mem_rd_valid, .mem_rd_req, .mem_rd_ready, .mem_rd_beat,
        .mem_wr_valid, .mem_wr_req, .mem_wr_beat, .mem_wr_ready,
        .mem_b_valid, .mem_b_ready, .rd_bursts, .last_rd, .wr_bursts, .last_wr
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            stop_run($sformatf("timeout, the run went past %0d cycles", cycle_limit));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // expected values and compare tasks
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] pat(logic [31:0] a);
        return {a[31:2], 2'b00} ^ PATTERN;  // initial memory content
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wd,
                                                logic [3:0] s);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                m[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return m;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_resp(int n, dc_resp_t got, dc_resp_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR t=%0t: entry %0d read data %h, expected %h",
                               $time, n, got.rdata, exp.rdata));
        end
    endtask

    task automatic compare_wr_req(int n, mem_wr_req_t got, mem_wr_req_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR t=%0t: entry %0d write-back address %h, expected %h",
                               $time, n, got.addr, exp.addr));
        end
    endtask

    task automatic verify_rd_req(int n, mem_rd_req_t got, mem_rd_req_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR t=%0t: entry %0d refill address %h, expected %h",
                               $time, n, got.addr, exp.addr));
        end
    endtask

    task automatic count_equal(int n, string what, int got, int exp);
        if (got != exp) begin
            stop_run($sformatf("ERR t=%0t: entry %0d %s %0d, expected %0d",
                               $time, n, what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    function automatic void push_entry(bit wr, logic [31:0] a, logic [31:0] d,
                                       logic [3:0] s, logic [31:0] e, bit rd, bit wb,
                                       logic [31:0] wa);
        stim_t t;
        t = '{wr, a, d, s, e, rd, wb, wa};
        tbl.push_back(t);
    endfunction

    function automatic void build_table();
        push_entry(0, 32'h014, 0, 0, pat(32'h014), 1, 0, 0);  // cold miss
        push_entry(0, 32'h01C, 0, 0, pat(32'h01C), 0, 0, 0);
        push_entry(1, 32'h018, ST1, 4'b0101, 0, 0, 0, 0);     // partial store hit
        push_entry(0, 32'h018, 0, 0, merge_bytes(pat(32'h018), ST1, 4'b0101), 0, 0, 0);
        push_entry(1, 32'h028, ST2, 4'b1100, 0, 1, 0, 0);     // store miss
        push_entry(0, 32'h028, 0, 0, merge_bytes(pat(32'h028), ST2, 4'b1100), 0, 0, 0);
        push_entry(0, 32'h02C, 0, 0, pat(32'h02C), 0, 0, 0);
        // set 4, lines A B C
        push_entry(0, 32'h040, 0, 0, pat(32'h040), 1, 0, 0);
        push_entry(0, 32'h140, 0, 0, pat(32'h140), 1, 0, 0);
        push_entry(0, 32'h044, 0, 0, pat(32'h044), 0, 0, 0);  // touch A
        push_entry(0, 32'h240, 0, 0, pat(32'h240), 1, 0, 0);  // evicts clean B
        push_entry(0, 32'h048, 0, 0, pat(32'h048), 0, 0, 0);
        push_entry(0, 32'h14C, 0, 0, pat(32'h14C), 1, 0, 0);
        // set 1, dirty line 0x010 goes out
        push_entry(0, 32'h110, 0, 0, pat(32'h110), 1, 0, 0);
        push_entry(0, 32'h210, 0, 0, pat(32'h210), 1, 1, 32'h010);
        push_entry(0, 32'h018, 0, 0, merge_bytes(pat(32'h018), ST1, 4'b0101), 1, 0, 0);
        push_entry(0, 32'h014, 0, 0, pat(32'h014), 0, 0, 0);
        // set 2, line dirtied by the store miss
        push_entry(0, 32'h120, 0, 0, pat(32'h120), 1, 0, 0);
        push_entry(0, 32'h224, 0, 0, pat(32'h224), 1, 1, 32'h020);
        push_entry(0, 32'h028, 0, 0, merge_bytes(pat(32'h028), ST2, 4'b1100), 1, 0, 0);
        push_entry(1, 32'h224, 32'hDEAD_BEEF, 4'b1111, 0, 0, 0, 0);
        push_entry(0, 32'h224, 0, 0, 32'hDEAD_BEEF, 0, 0, 0);
    endfunction

    task automatic apply_entry(int n, stim_t t);
        int          rd0;
        int          wr0;
        int          lat;
        dc_resp_t    exp;
        mem_rd_req_t exp_rd;
        mem_wr_req_t exp_wr;
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        lat = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req.addr  = addr_fields_t'(t.addr);
        req.wdata = t.wdata;
        req.wstrb = t.wr ? t.wstrb : 4'b0000;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        exp.rdata = t.exp_rdata;
        check_resp(n, resp, exp);
        req_valid = 1'b0;
        count_equal(n, "read bursts", rd_bursts - rd0, int'(t.exp_rd));
        count_equal(n, "write-back bursts", wr_bursts - wr0, int'(t.exp_wb));
        if (t.exp_rd) begin
            exp_rd.addr = {t.addr[31:4], 4'b0000};
            verify_rd_req(n, last_rd, exp_rd);
        end else begin
            count_equal(n, "hit latency", lat, 1);
        end
        if (t.exp_wb) begin
            exp_wr.addr = t.wb_addr;
            compare_wr_req(n, last_wr, exp_wr);
        end
    endtask

    initial begin
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        cycle_limit = RST_CYC + ENTRY_CYC * tbl.size();
        repeat (RST_CYC) @(negedge clk);
        rstn = 1'b1;
        foreach (tbl[i]) begin
            apply_entry(i, tbl[i]);
        end
        @(negedge clk);
        $display("%0d table entries checked", tbl.size());
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== dcache.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/mem_bus_pkg.sv
verilog/way_ram.sv
verilog/replace_state.sv
verilog/writeback_unit.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/mem_model.sv
sim/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/mem_bus_pkg.sv
      - verilog/way_ram.sv
      - verilog/replace_state.sv
      - verilog/writeback_unit.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/mem_model.sv
      - sim/tb_dcache.sv
